// File: mipsCpuBus.f
+incdir+source
source/mipsPkg.sv
source/registerFile.sv
source/executeUnit.sv
source/controlUnit.sv
source/mipsCpuBus.sv
tests/mipsCpuBusAsserts.sv
tests/mipsCpuBusTb.sv

// File: runSim.sh
#!/usr/bin/env bash
# Build and run the CPU testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f mipsCpuBus.f \
    --top-module mipsCpuBusTb \
    -o mipsCpuBusSim

./obj_dir/mipsCpuBusSim | tee sim.log

if grep -q "Simulation finished: PASS" sim.log; then
    exit 0
else
    exit 1
fi

// File: tests/mipsCpuBusTb.sv
// CPU testbench with a random-wait Avalon memory. Programs run from RESET_VECTOR, data near 0x1000
`default_nettype none

`include "mipsCpu_cfg.svh"

module mipsCpuBusTb;
    timeunit 1ns;
    timeprecision 1ns;

    localparam int CLOCK_PERIOD = 100;
    localparam int STEP_LIMIT = 200;
    // Three programs, worst case ten cycles per instruction, plus reset time
    localparam longint TIMEOUT_NS = 3 * (STEP_LIMIT * 10 + 40) * CLOCK_PERIOD;
    localparam logic [31:0] RESET_PC = `RESET_VECTOR;
    localparam logic [31:0] HALT_PC = `HALT_ADDRESS;

    logic        clk;
    logic        reset;
    logic        waitrequest;
    logic [31:0] readdata;
    logic        active;
    logic [31:0] register_v0;
    logic [31:0] address;
    logic        write;
    logic        read;
    logic [31:0] writedata;
    logic [3:0]  byteenable;

    integer      seed = 32'h0c72_32ca;
    int          errors = 0;
    logic        firstReadSeen = 1'b0;
    logic        resetApplied = 1'b0;
    logic [31:0] prog [$];
    // Word-addressed memories of the DUT side and of the reference
    logic [31:0] dutMem [logic [29:0]];
    logic [31:0] refMem [logic [29:0]];

    mipsCpuBus uut (
        .clk         (clk),
        .reset       (reset),
        .active      (active),
        .register_v0 (register_v0),
        .address     (address),
        .write       (write),
        .read        (read),
        .waitrequest (waitrequest),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .readdata    (readdata)
    );

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        waitrequest = 1'b0;
        readdata = '0;
    end

    always #(CLOCK_PERIOD / 2) clk = ~clk;

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        if (actual !== expected) begin
            errors++;
            $display("Error at %0t ns: %s got %h expected %h", $time, what, actual, expected);
        end
    endtask

    function automatic logic [31:0] encR(input logic [4:0] rs, input logic [4:0] rt,
                                         input logic [4:0] rd, input logic [4:0] sh,
                                         input logic [5:0] fn);
        return {6'd0, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] encI(input logic [5:0] op, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [15:0] randomImm();
        logic [31:0] r;
        r = $random(seed);
        return r[15:0];
    endfunction

    // Memory model: commit on the completing edge, respond shortly after
    always begin
        logic [31:0] r;
        @(posedge clk);
        if (!reset && write === 1'b1 && !waitrequest) begin
            dutMem[address[31:2]] = writedata;
        end
        #5;
        r = $random(seed);
        waitrequest = (r[1:0] == 2'b00);
        readdata = dutMem.exists(address[31:2]) ? dutMem[address[31:2]] : '0;
    end

    // Bus idle in reset and after halt, first fetch at the reset vector
    always @(posedge clk) begin
        if (reset) begin
            // Synchronous reset defines the outputs only after its first edge
            if (resetApplied) begin
                checkValue(32'(read === 1'b1 || write === 1'b1), 32'd0, "bus busy during reset");
            end
            resetApplied <= 1'b1;
            firstReadSeen <= 1'b0;
        end else begin
            // Whole-word transfers only
            if (read === 1'b1 || write === 1'b1) begin
                checkValue(32'(byteenable), 32'h0000_000f, "byteenable");
            end
            if (read === 1'b1 && !firstReadSeen) begin
                checkValue(address, RESET_PC, "first fetch address");
                firstReadSeen <= 1'b1;
            end
            if (active === 1'b0) begin
                checkValue(32'(read === 1'b1 || write === 1'b1), 32'd0, "bus busy after halt");
            end
        end
    end

    // Instruction-set model with one delay slot, runs on refMem
    function automatic logic [31:0] referenceRun();
        logic [31:0] r [32];
        logic [31:0] pc;
        logic [31:0] pc4;
        logic [31:0] nextPc;
        logic [31:0] i;
        logic [31:0] se;
        logic [31:0] ze;
        logic [31:0] ea;
        logic [31:0] target;
        logic [31:0] pendTarget;
        logic        pend;
        logic        redirect;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  sh;
        for (int k = 0; k < 32; k++) begin
            r[k] = '0;
        end
        pc = RESET_PC;
        pend = 1'b0;
        pendTarget = '0;
        for (int step = 0; step < STEP_LIMIT; step++) begin
            i = refMem.exists(pc[31:2]) ? refMem[pc[31:2]] : '0;
            rs = i[25:21];
            rt = i[20:16];
            rd = i[15:11];
            sh = i[10:6];
            se = {{16{i[15]}}, i[15:0]};
            ze = {16'd0, i[15:0]};
            ea = r[rs] + se;
            pc4 = pc + 32'd4;
            redirect = 1'b0;
            target = pc4 + {se[29:0], 2'b00};
            case (i[31:26])
                6'd0: case (i[5:0])
                    6'd0:  r[rd] = r[rt] << sh;
                    6'd2:  r[rd] = r[rt] >> sh;
                    6'd3:  r[rd] = $signed(r[rt]) >>> sh;
                    6'd8: begin
                        redirect = 1'b1;
                        target = r[rs];
                    end
                    6'd33: r[rd] = r[rs] + r[rt];
                    6'd35: r[rd] = r[rs] - r[rt];
                    6'd36: r[rd] = r[rs] & r[rt];
                    6'd37: r[rd] = r[rs] | r[rt];
                    6'd38: r[rd] = r[rs] ^ r[rt];
                    6'd42: r[rd] = {31'd0, $signed(r[rs]) < $signed(r[rt])};
                    6'd43: r[rd] = {31'd0, r[rs] < r[rt]};
                    default: ;
                endcase
                6'd2: begin
                    redirect = 1'b1;
                    target = {pc4[31:28], i[25:0], 2'b00};
                end
                6'd4:  redirect = (r[rs] == r[rt]);
                6'd5:  redirect = (r[rs] != r[rt]);
                6'd9:  r[rt] = r[rs] + se;
                6'd10: r[rt] = {31'd0, $signed(r[rs]) < $signed(se)};
                6'd11: r[rt] = {31'd0, r[rs] < se};
                6'd12: r[rt] = r[rs] & ze;
                6'd13: r[rt] = r[rs] | ze;
                6'd14: r[rt] = r[rs] ^ ze;
                6'd15: r[rt] = {i[15:0], 16'd0};
                6'd35: r[rt] = refMem.exists(ea[31:2]) ? refMem[ea[31:2]] : '0;
                6'd43: refMem[ea[31:2]] = r[rt];
                default: ;
            endcase
            r[0] = '0;
            // Jump lands after its delay slot
            nextPc = pend ? pendTarget : pc4;
            if (redirect) begin
                pendTarget = target;
            end
            pend = redirect;
            pc = nextPc;
            if (pc == HALT_PC) begin
                break;
            end
        end
        return r[2];
    endfunction

    // Append an op writing r10, then fold r10 into v0
    task automatic pushFolded(input logic [31:0] instr);
        prog.push_back(instr);
        prog.push_back(encR(5'd2, 5'd10, 5'd2, 5'd0, 6'd38));
    endtask

    task automatic buildAluProgram();
        logic [5:0] rFuncs [7];
        logic [5:0] shFuncs [3];
        logic [15:0] r;
        rFuncs = '{6'd33, 6'd35, 6'd36, 6'd37, 6'd38, 6'd42, 6'd43};
        shFuncs = '{6'd0, 6'd2, 6'd3};
        prog.push_back(encI(6'd15, 5'd0, 5'd8, randomImm()));
        prog.push_back(encI(6'd13, 5'd8, 5'd8, randomImm()));
        prog.push_back(encI(6'd9, 5'd0, 5'd9, randomImm()));
        foreach (rFuncs[k]) begin
            pushFolded(encR(5'd8, 5'd9, 5'd10, 5'd0, rFuncs[k]));
        end
        foreach (shFuncs[k]) begin
            r = randomImm();
            pushFolded(encR(5'd0, 5'd8, 5'd10, r[4:0], shFuncs[k]));
        end
        // ADDIU through LUI
        for (int op = 9; op <= 15; op++) begin
            pushFolded(encI(6'(op), 5'd8, 5'd10, randomImm()));
        end
    endtask

    // Branch, delay slot that writes v0, then an op skipped when taken
    task automatic pushBranch(input logic [31:0] br);
        prog.push_back(br);
        prog.push_back(encI(6'd9, 5'd2, 5'd2, randomImm()));
        prog.push_back(encI(6'd14, 5'd2, 5'd2, randomImm()));
    endtask

    task automatic buildBranchProgram();
        logic [31:0] jumpAddr;
        prog.push_back(encI(6'd9, 5'd0, 5'd8, randomImm()));
        prog.push_back(encI(6'd9, 5'd8, 5'd9, 16'd1));
        pushBranch(encI(6'd4, 5'd8, 5'd8, 16'd2));
        pushBranch(encI(6'd5, 5'd8, 5'd8, 16'd2));
        pushBranch(encI(6'd5, 5'd8, 5'd9, 16'd2));
        pushBranch(encI(6'd4, 5'd8, 5'd9, 16'd2));
        jumpAddr = RESET_PC + 32'(4 * (prog.size() + 3));
        pushBranch({6'd2, jumpAddr[27:2]});
    endtask

    task automatic buildMemoryProgram();
        prog.push_back(encI(6'd9, 5'd0, 5'd8, 16'h1000));
        for (int k = 0; k < 4; k++) begin
            prog.push_back(encI(6'd15, 5'd0, 5'd9, randomImm()));
            prog.push_back(encI(6'd13, 5'd9, 5'd9, randomImm()));
            prog.push_back(encI(6'd43, 5'd8, 5'd9, 16'(4 * k)));
        end
        for (int k = 0; k < 4; k++) begin
            prog.push_back(encI(6'd35, 5'd8, 5'd10, 16'(4 * k)));
            prog.push_back(encR(5'd2, 5'd10, 5'd2, 5'd0, 6'd33));
        end
        // Sum goes out and comes back into v0
        prog.push_back(encI(6'd43, 5'd8, 5'd2, 16'd64));
        prog.push_back(encI(6'd9, 5'd0, 5'd2, 16'd0));
        prog.push_back(encI(6'd35, 5'd8, 5'd2, 16'd64));
    endtask

    task automatic runProgram(input int which, input string name);
        logic [31:0] expectedV0;
        @(posedge clk);
        #5;
        reset = 1'b1;
        prog.delete();
        dutMem.delete();
        refMem.delete();
        case (which)
            0: buildAluProgram();
            1: buildBranchProgram();
            default: buildMemoryProgram();
        endcase
        // JR to zero with a no-op in its delay slot
        prog.push_back(encR(5'd0, 5'd0, 5'd0, 5'd0, 6'd8));
        prog.push_back(32'd0);
        foreach (prog[k]) begin
            dutMem[RESET_PC[31:2] + 30'(k)] = prog[k];
            refMem[RESET_PC[31:2] + 30'(k)] = prog[k];
        end
        expectedV0 = referenceRun();
        repeat (16) @(posedge clk);
        #5;
        reset = 1'b0;
        @(posedge clk);
        while (active !== 1'b0) begin
            @(posedge clk);
        end
        // Let the monitor watch the halted bus
        repeat (10) @(posedge clk);
        checkValue(register_v0, expectedV0, {name, " register_v0"});
        checkValue(32'(dutMem.num()), 32'(refMem.num()), {name, " memory word count"});
        foreach (refMem[k]) begin
            checkValue(dutMem.exists(k) ? dutMem[k] : 32'hxxxx_xxxx, refMem[k],
                       $sformatf("%s memory word %h", name, {k, 2'b00}));
        end
    endtask

    initial begin
        runProgram(0, "alu");
        runProgram(1, "branch");
        runProgram(2, "memory");
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the CPU did not halt within the time limit");
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/mipsCpuBusAsserts.sv
// Avalon and halt checks for the CPU top. Only meaningful once reset has been applied
`default_nettype none

module mipsCpuBusAsserts (
    input logic        clk,
    input logic        reset,
    input logic        active,
    input logic        read,
    input logic        write,
    input logic        waitrequest,
    input logic [31:0] address,
    input logic [31:0] writedata
);
    timeunit 1ns;
    timeprecision 1ns;

    // Master holds a stalled transfer unchanged
    property holdWhileWaiting;
        @(posedge clk) disable iff (reset)
        ((read || write) && waitrequest) |=>
            ($stable(address) && $stable(read) && $stable(write) && $stable(writedata));
    endproperty

    assert property (holdWhileWaiting)
        else $error("Bus outputs changed while waitrequest was high");

    // Never a read and a write at once
    assert property (@(posedge clk) disable iff (reset) !(read && write))
        else $error("Read and write were high together");

    // Halted CPU leaves the bus idle
    assert property (@(posedge clk) disable iff (reset) !active |-> (!read && !write))
        else $error("Bus access while the CPU was halted");

    // Only reset wakes the CPU again
    assert property (@(posedge clk) (!active && !reset) |=> !active)
        else $error("Active rose again without reset");

endmodule

bind mipsCpuBus mipsCpuBusAsserts busChecks (
    .clk         (clk),
    .reset       (reset),
    .active      (active),
    .read        (read),
    .write       (write),
    .waitrequest (waitrequest),
    .address     (address),
    .writedata   (writedata)
);

`default_nettype wire

// File: source/mipsCpuBus.sv
// Avalon master CPU top. Word-aligned LW and SW only and byteenable is always all ones
`default_nettype none

`include "mipsCpu_cfg.svh"

module mipsCpuBus
    import mipsPkg::*;
(
    input  logic                       clk,
    input  logic                       reset,
    output logic                       active,
    output word_t                      register_v0,
    // Avalon master side
    output word_t                      address,
    output logic                       write,
    output logic                       read,
    input  logic                       waitrequest,
    output word_t                      writedata,
    output logic [`WORD_WIDTH/8-1:0]   byteenable,
    input  word_t                      readdata
);

    // Held instruction and its address
    word_t     instruction;
    word_t     pc;

    // Register file read side
    regIndex_t rsIndex;
    regIndex_t rtIndex;
    word_t     rsValue;
    word_t     rtValue;

    // Decode and ALU outputs
    word_t     result;
    regIndex_t destIndex;
    logic      writesReg;
    logic      isLoad;
    logic      isStore;
    logic      redirect;
    word_t     redirectTarget;

    // Register file write port
    logic      regWriteEnable;
    regIndex_t regWriteIndex;
    word_t     regWriteData;

    // No partial-word transfers
    assign byteenable = `BYTE_ENABLE_ALL;

    controlUnit control (
        .clk            (clk),
        .reset          (reset),
        .active         (active),
        .address        (address),
        .read           (read),
        .write          (write),
        .waitrequest    (waitrequest),
        .writedata      (writedata),
        .readdata       (readdata),
        .instruction    (instruction),
        .pc             (pc),
        .rtValue        (rtValue),
        .result         (result),
        .destIndex      (destIndex),
        .writesReg      (writesReg),
        .isLoad         (isLoad),
        .isStore        (isStore),
        .redirect       (redirect),
        .redirectTarget (redirectTarget),
        .regWriteEnable (regWriteEnable),
        .regWriteIndex  (regWriteIndex),
        .regWriteData   (regWriteData)
    );

    executeUnit execute (
        .instruction    (instruction),
        .pc             (pc),
        .rsValue        (rsValue),
        .rtValue        (rtValue),
        .rsIndex        (rsIndex),
        .rtIndex        (rtIndex),
        .result         (result),
        .destIndex      (destIndex),
        .writesReg      (writesReg),
        .isLoad         (isLoad),
        .isStore        (isStore),
        .redirect       (redirect),
        .redirectTarget (redirectTarget)
    );

    registerFile registers (
        .clk         (clk),
        .reset       (reset),
        .rsIndex     (rsIndex),
        .rtIndex     (rtIndex),
        .rsValue     (rsValue),
        .rtValue     (rtValue),
        .writeEnable (regWriteEnable),
        .writeIndex  (regWriteIndex),
        .writeData   (regWriteData),
        .registerV0  (register_v0)
    );

endmodule

`default_nettype wire

// File: source/controlUnit.sv
// Multicycle FSM and Avalon driver. Leaves reset through one startup cycle and stays halted until reset
`default_nettype none

`include "mipsCpu_cfg.svh"

module controlUnit
    import mipsPkg::*;
(
    input  logic      clk,
    input  logic      reset,
    output logic      active,
    output word_t     address,
    output logic      read,
    output logic      write,
    input  logic      waitrequest,
    output word_t     writedata,
    input  word_t     readdata,
    output word_t     instruction,
    output word_t     pc,
    input  word_t     rtValue,
    input  word_t     result,
    input  regIndex_t destIndex,
    input  logic      writesReg,
    input  logic      isLoad,
    input  logic      isStore,
    input  logic      redirect,
    input  word_t     redirectTarget,
    output logic      regWriteEnable,
    output regIndex_t regWriteIndex,
    output word_t     regWriteData
);

    cpuState_t state;
    cpuState_t nextState;

    // Delay-slot tracking
    logic  pendingValid;
    word_t pendingTarget;

    logic  memAccess;
    logic  busDone;
    logic  instrDone;
    logic  haltNext;
    word_t pcPlus4;
    word_t nextPc;

    assign memAccess = isLoad || isStore;
    assign busDone   = !waitrequest;

    // Instruction ends in EXECUTE unless it needs the bus again
    assign instrDone = ((state == EXECUTE) && !memAccess)
                     || ((state == MEMORY) && busDone);

    // Pending jump wins once the delay slot has run
    assign pcPlus4  = pc + word_t'(4);
    assign nextPc   = pendingValid ? pendingTarget : pcPlus4;
    assign haltNext = (nextPc == `HALT_ADDRESS);

    // Bus outputs only depend on held state
    assign address   = (state == MEMORY) ? result : pc;
    assign read      = (state == FETCH) || ((state == MEMORY) && isLoad);
    assign write     = (state == MEMORY) && isStore;
    assign writedata = rtValue;

    // ALU results retire in EXECUTE
    // Load data retires when the read completes
    assign regWriteEnable = ((state == EXECUTE) && writesReg && !isLoad)
                          || ((state == MEMORY) && isLoad && busDone);
    assign regWriteIndex  = destIndex;
    assign regWriteData   = (state == MEMORY) ? readdata : result;

    always_comb begin
        nextState = state;
        case (state)
            FETCH: begin
                if (busDone) begin
                    nextState = EXECUTE;
                end
            end
            EXECUTE: begin
                if (memAccess) begin
                    nextState = MEMORY;
                end
            end
            // Startup cycle after reset only
            HALT: begin
                if (active) begin
                    nextState = FETCH;
                end
            end
            default: ;
        endcase
        // Skip the fetch entirely at the halt address
        if (instrDone) begin
            nextState = haltNext ? HALT : FETCH;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= HALT;
            active       <= 1'b1;
            pc           <= `RESET_VECTOR;
            instruction  <= '0;
            pendingValid <= 1'b0;
        end else begin
            state <= nextState;
            // Latch opcode word on fetch completion
            if ((state == FETCH) && busDone) begin
                instruction <= readdata;
            end
            if (instrDone) begin
                pc <= nextPc;
                // Only non-memory instructions redirect
                pendingValid <= (state == EXECUTE) && redirect;
                if (haltNext) begin
                    active <= 1'b0;
                end
            end
        end
    end

    // Target only meaningful while pendingValid is set
    always_ff @(posedge clk) begin
        if ((state == EXECUTE) && redirect) begin
            pendingTarget <= redirectTarget;
        end
    end

endmodule

`default_nettype wire

// File: source/executeUnit.sv
// Pure combinational decode and ALU. Opcodes and function codes not listed act as no-ops
`default_nettype none

module executeUnit
    import mipsPkg::*;
(
    input  word_t     instruction,
    input  word_t     pc,
    input  word_t     rsValue,
    input  word_t     rtValue,
    output regIndex_t rsIndex,
    output regIndex_t rtIndex,
    output word_t     result,
    output regIndex_t destIndex,
    output logic      writesReg,
    output logic      isLoad,
    output logic      isStore,
    output logic      redirect,
    output word_t     redirectTarget
);

    opcode_t    opcode;
    funct_t     funct;
    regIndex_t  rdIndex;
    logic [4:0] shamt;
    immediate_t imm;
    logic [25:0] jumpIndex;

    word_t signImm;
    word_t zeroImm;
    word_t pcPlus4;
    word_t branchTarget;
    word_t jumpTarget;

    // Instruction fields
    assign opcode    = opcode_t'(instruction[31:26]);
    assign rsIndex   = instruction[25:21];
    assign rtIndex   = instruction[20:16];
    assign rdIndex   = instruction[15:11];
    assign shamt     = instruction[10:6];
    assign funct     = funct_t'(instruction[5:0]);
    assign imm       = instruction[15:0];
    assign jumpIndex = instruction[25:0];

    // Immediate extensions
    assign signImm = {{($bits(word_t) - $bits(immediate_t)){imm[15]}}, imm};
    assign zeroImm = {{($bits(word_t) - $bits(immediate_t)){1'b0}}, imm};

    // Targets relative to the delay slot address
    assign pcPlus4      = pc + word_t'(4);
    assign branchTarget = pcPlus4 + {signImm[$bits(word_t)-3:0], 2'b00};
    assign jumpTarget   = {pcPlus4[$bits(word_t)-1:28], jumpIndex, 2'b00};

    always_comb begin
        // No-op unless decoded below
        result         = '0;
        destIndex      = rtIndex;
        writesReg      = 1'b0;
        isLoad         = 1'b0;
        isStore        = 1'b0;
        redirect       = 1'b0;
        redirectTarget = branchTarget;

        case (opcode)
            OP_SPECIAL: begin
                // R-type writes rd
                destIndex = rdIndex;
                writesReg = 1'b1;
                case (funct)
                    FN_ADDU: result = rsValue + rtValue;
                    FN_SUBU: result = rsValue - rtValue;
                    FN_AND:  result = rsValue & rtValue;
                    FN_OR:   result = rsValue | rtValue;
                    FN_XOR:  result = rsValue ^ rtValue;
                    FN_SLT:  result = word_t'($signed(rsValue) < $signed(rtValue));
                    FN_SLTU: result = word_t'(rsValue < rtValue);
                    FN_SLL:  result = rtValue << shamt;
                    FN_SRL:  result = rtValue >> shamt;
                    // Sign bit fills from the left
                    FN_SRA:  result = word_t'($signed(rtValue) >>> shamt);
                    FN_JR: begin
                        writesReg      = 1'b0;
                        redirect       = 1'b1;
                        redirectTarget = rsValue;
                    end
                    default: writesReg = 1'b0;
                endcase
            end
            OP_J: begin
                redirect       = 1'b1;
                redirectTarget = jumpTarget;
            end
            // Branch target already selected by default
            OP_BEQ: redirect = (rsValue == rtValue);
            OP_BNE: redirect = (rsValue != rtValue);
            OP_ADDIU: begin
                result    = rsValue + signImm;
                writesReg = 1'b1;
            end
            OP_SLTI: begin
                result    = word_t'($signed(rsValue) < $signed(signImm));
                writesReg = 1'b1;
            end
            // Unsigned compare against the sign-extended immediate
            OP_SLTIU: begin
                result    = word_t'(rsValue < signImm);
                writesReg = 1'b1;
            end
            OP_ANDI: begin
                result    = rsValue & zeroImm;
                writesReg = 1'b1;
            end
            OP_ORI: begin
                result    = rsValue | zeroImm;
                writesReg = 1'b1;
            end
            OP_XORI: begin
                result    = rsValue ^ zeroImm;
                writesReg = 1'b1;
            end
            OP_LUI: begin
                result    = {imm, {($bits(word_t) - $bits(immediate_t)){1'b0}}};
                writesReg = 1'b1;
            end
            // Effective address in result for memory ops
            OP_LW: begin
                result    = rsValue + signImm;
                writesReg = 1'b1;
                isLoad    = 1'b1;
            end
            OP_SW: begin
                result  = rsValue + signImm;
                isStore = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: source/registerFile.sv
// General registers with combinational reads. Register zero reads zero and drops writes
`default_nettype none

`include "mipsCpu_cfg.svh"

module registerFile
    import mipsPkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  regIndex_t rsIndex,
    input  regIndex_t rtIndex,
    output word_t     rsValue,
    output word_t     rtValue,
    input  logic      writeEnable,
    input  regIndex_t writeIndex,
    input  word_t     writeData,
    output word_t     registerV0
);

    word_t regs [`REG_COUNT];

    // Write lands at the next edge
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && (writeIndex != '0)) begin
            regs[writeIndex] <= writeData;
        end
    end

    // Zero register forced on read
    assign rsValue = (rsIndex == '0) ? '0 : regs[rsIndex];
    assign rtValue = (rtIndex == '0) ? '0 : regs[rtIndex];

    // Result register tap
    assign registerV0 = regs[`V0_INDEX];

endmodule

`default_nettype wire

// File: source/mipsPkg.sv
// Types shared by the CPU blocks. Only the implemented opcodes and function codes are listed
`default_nettype none

`include "mipsCpu_cfg.svh"

package mipsPkg;

    // Machine word for data and addresses
    typedef logic [`WORD_WIDTH-1:0] word_t;

    // Register number
    typedef logic [`REG_INDEX_WIDTH-1:0] regIndex_t;

    // Immediate field of I-type instructions
    typedef logic [15:0] immediate_t;

    // Primary opcodes, bits 31..26
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'd0,
        OP_J       = 6'd2,
        OP_BEQ     = 6'd4,
        OP_BNE     = 6'd5,
        OP_ADDIU   = 6'd9,
        OP_SLTI    = 6'd10,
        OP_SLTIU   = 6'd11,
        OP_ANDI    = 6'd12,
        OP_ORI     = 6'd13,
        OP_XORI    = 6'd14,
        OP_LUI     = 6'd15,
        OP_LW      = 6'd35,
        OP_SW      = 6'd43
    } opcode_t;

    // SPECIAL function codes, bits 5..0
    typedef enum logic [5:0] {
        FN_SLL  = 6'd0,
        FN_SRL  = 6'd2,
        FN_SRA  = 6'd3,
        FN_JR   = 6'd8,
        FN_ADDU = 6'd33,
        FN_SUBU = 6'd35,
        FN_AND  = 6'd36,
        FN_OR   = 6'd37,
        FN_XOR  = 6'd38,
        FN_SLT  = 6'd42,
        FN_SLTU = 6'd43
    } funct_t;

    // Multicycle FSM states
    typedef enum logic [1:0] {
        FETCH   = 2'd0,
        EXECUTE = 2'd1,
        MEMORY  = 2'd2,
        HALT    = 2'd3
    } cpuState_t;

endpackage

`default_nettype wire

// File: source/mipsCpu_cfg.svh
// Widths and fixed addresses of the CPU. RESET_VECTOR and HALT_ADDRESS must match the memory map
`ifndef MIPS_CPU_CFG_SVH
`define MIPS_CPU_CFG_SVH

// Data and address width
`define WORD_WIDTH 32

// General register file size
`define REG_COUNT 32
`define REG_INDEX_WIDTH 5

// Register whose content is exported as register_v0
`define V0_INDEX 2

// First fetch address after reset
`define RESET_VECTOR 32'hBFC0_0000

// A fetch at this address stops the CPU
`define HALT_ADDRESS 32'h0000_0000

// Only whole-word transfers exist
`define BYTE_ENABLE_ALL 4'b1111

`endif
